// ==== source/isaPkg.sv ====
// RV32I subset definitions
package isaPkg;

    localparam int XLEN = 32;

    // architectural register names
    typedef enum logic [4:0] {
        x0,  x1,  x2,  x3,  x4,  x5,  x6,  x7,
        x8,  x9,  x10, x11, x12, x13, x14, x15,
        x16, x17, x18, x19, x20, x21, x22, x23,
        x24, x25, x26, x27, x28, x29, x30, x31
    } regName;

    // major opcodes, HALT is the custom all-ones code
    typedef enum logic [6:0] {
        OP_R      = 7'b0110011,
        OP_I      = 7'b0010011,
        OP_LUI    = 7'b0110111,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_BRANCH = 7'b1100011,
        OP_JAL    = 7'b1101111,
        OP_HALT   = 7'b1111111
    } opcode;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLL,
        ALU_SRL,
        ALU_PASSB
    } aluOperation;

    // branch funct3
    localparam logic [2:0] F3_BEQ = 3'b000;
    localparam logic [2:0] F3_BNE = 3'b001;

endpackage

// ==== source/corePkg.sv ====
// pipeline control encodings
package corePkg;

    // how execute picks its ALU operation
    typedef enum logic [1:0] {
        ALU_CLASS_ADD,
        ALU_CLASS_FUNC,
        ALU_CLASS_PASS
    } aluClass;

    // second ALU operand
    typedef enum logic [1:0] {
        SRC2_REG,
        SRC2_IMM_I,
        SRC2_IMM_S,
        SRC2_IMM_U
    } aluSrc2;

    typedef enum logic [1:0] {
        FWD_REG,
        FWD_MEM,
        FWD_WB
    } forwardSel;

    // memory sizes in words
    localparam int IMEM_DEPTH = 256;
    localparam int DMEM_DEPTH = 64;

endpackage

// ==== source/controlUnit.sv ====
// main decoder
`timescale 1ns/1ps

module controlUnit (
    input  isaPkg::opcode    opcode,
    input  logic             enable,
    output logic             regWrite,
    output logic             memRead,
    output logic             memWrite,
    output logic             memToReg,
    output logic             branch,
    output logic             jump,
    output logic             halt,
    output corePkg::aluClass aluClass,
    output corePkg::aluSrc2  aluSrc2
);
    import isaPkg::*;
    import corePkg::*;

    always_comb begin
        // all-zero bundle doubles as the bubble
        regWrite = 1'b0;
        memRead  = 1'b0;
        memWrite = 1'b0;
        memToReg = 1'b0;
        branch   = 1'b0;
        jump     = 1'b0;
        halt     = 1'b0;
        aluClass = ALU_CLASS_ADD;
        aluSrc2  = SRC2_REG;
        if (enable) begin
            case (opcode)
                OP_R: begin
                    regWrite = 1'b1;
                    aluClass = ALU_CLASS_FUNC;
                end
                OP_I: begin
                    regWrite = 1'b1;
                    aluSrc2  = SRC2_IMM_I;
                end
                OP_LUI: begin
                    regWrite = 1'b1;
                    aluClass = ALU_CLASS_PASS;
                    aluSrc2  = SRC2_IMM_U;
                end
                OP_LOAD: begin
                    regWrite = 1'b1;
                    memRead  = 1'b1;
                    memToReg = 1'b1;
                    aluSrc2  = SRC2_IMM_I;
                end
                OP_STORE: begin
                    memWrite = 1'b1;
                    aluSrc2  = SRC2_IMM_S;
                end
                OP_BRANCH: branch = 1'b1;
                OP_JAL: begin
                    // link value rides in the U slot
                    regWrite = 1'b1;
                    jump     = 1'b1;
                    aluClass = ALU_CLASS_PASS;
                    aluSrc2  = SRC2_IMM_U;
                end
                OP_HALT: halt = 1'b1;
                default: ;
            endcase
        end
    end

endmodule

// ==== source/regFile.sv ====
// integer register file
`timescale 1ns/1ps

module regFile (
    input  logic                     clk,
    input  logic                     rstN,
    input  logic                     wen,
    input  isaPkg::regName           rs1,
    input  isaPkg::regName           rs2,
    input  isaPkg::regName           rd,
    input  logic [isaPkg::XLEN-1:0]  dataIn,
    output logic [isaPkg::XLEN-1:0]  rs1Data,
    output logic [isaPkg::XLEN-1:0]  rs2Data
);
    import isaPkg::*;

    logic [XLEN-1:0] regs [2**$bits(regName)];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < 2**$bits(regName); i++) begin
                regs[i] <= '0;
            end
        end else if (wen && rd != x0) begin
            regs[rd] <= dataIn;
        end
    end

    // same-cycle write shows up on the read ports
    assign rs1Data = (wen && rd != x0 && rd == rs1) ? dataIn : regs[rs1];
    assign rs2Data = (wen && rd != x0 && rd == rs2) ? dataIn : regs[rs2];

endmodule

// ==== source/hazardUnit.sv ====
// stall and freeze control
`timescale 1ns/1ps

module hazardUnit (
    input  isaPkg::regName rs1ID,
    input  isaPkg::regName rs2ID,
    input  isaPkg::regName rdEx,
    input  logic           memReadEx,
    input  logic           regWriteEx,
    input  logic           branchID,
    input  logic           memBusy,
    output logic           pcWrite,
    output logic           ifIdWrite,
    output logic           idExEnable,
    output logic           freeze
);
    import isaPkg::*;

    logic rdMatch;
    logic loadUse;
    logic branchWait;
    logic stall;

    assign rdMatch = (rdEx != x0) && (rdEx == rs1ID || rdEx == rs2ID);

    // load result is not ready before the memory stage
    assign loadUse = memReadEx && rdMatch;
    // compare in decode only sees the memory stage
    assign branchWait = branchID && regWriteEx && rdMatch;
    assign stall = loadUse || branchWait;

    assign freeze     = memBusy;
    assign pcWrite    = !stall && !memBusy;
    assign ifIdWrite  = !stall && !memBusy;
    assign idExEnable = !stall;

endmodule

// ==== source/alu.sv ====
// execute-stage ALU
`timescale 1ns/1ps

module alu (
    input  corePkg::aluClass         aluClass,
    input  logic [2:0]               funct3,
    input  logic [6:0]               funct7,
    input  logic [isaPkg::XLEN-1:0]  a,
    input  logic [isaPkg::XLEN-1:0]  b,
    output logic [isaPkg::XLEN-1:0]  result,
    output logic                     zero
);
    import isaPkg::*;
    import corePkg::*;

    aluOperation op;

    // R-type only reaches the function decode
    always_comb begin
        op = ALU_ADD;
        if (aluClass == ALU_CLASS_PASS) begin
            op = ALU_PASSB;
        end else if (aluClass == ALU_CLASS_FUNC) begin
            case (funct3)
                3'b000:  op = funct7[5] ? ALU_SUB : ALU_ADD;
                3'b001:  op = ALU_SLL;
                3'b010:  op = ALU_SLT;
                3'b100:  op = ALU_XOR;
                3'b101:  op = ALU_SRL;
                3'b110:  op = ALU_OR;
                3'b111:  op = ALU_AND;
                default: op = ALU_ADD;
            endcase
        end
    end

    always_comb begin
        case (op)
            ALU_SUB:   result = a - b;
            ALU_AND:   result = a & b;
            ALU_OR:    result = a | b;
            ALU_XOR:   result = a ^ b;
            ALU_SLT:   result = {{(XLEN-1){1'b0}}, $signed(a) < $signed(b)};
            ALU_SLL:   result = a << b[4:0];
            ALU_SRL:   result = a >> b[4:0];
            ALU_PASSB: result = b;
            default:   result = a + b;
        endcase
    end

    assign zero = (result == '0);

endmodule

// ==== source/processor.sv ====
// five-stage pipeline core
`timescale 1ns/1ps

module processor (
    input  logic                     clk,
    input  logic                     rstN,
    input  logic                     startProcess,
    output logic                     endProcess,
    input  logic [isaPkg::XLEN-1:0]  instructionIF,
    output logic [isaPkg::XLEN-1:0]  pcIF,
    input  logic [isaPkg::XLEN-1:0]  memRData,
    input  logic                     memReady,
    output logic                     memRead,
    output logic                     memWrite,
    output logic [isaPkg::XLEN-1:0]  memAddr,
    output logic [isaPkg::XLEN-1:0]  memWData
);
    import isaPkg::*;
    import corePkg::*;

    logic running;
    logic pcWrite, ifIdWrite, idExEnable, freeze, memBusy;

    // decode stage
    logic [XLEN-1:0] instrID, pcID, rs1DataID, rs2DataID;
    logic [XLEN-1:0] immI, immS, immB, immU, immJ;
    logic [XLEN-1:0] cmpA, cmpB, memFwd, targetID;
    opcode opcodeID;
    regName rs1ID, rs2ID, rdID;
    logic regWriteCU, memReadCU, memWriteCU, memToRegCU, branchCU, jumpCU, haltCU;
    logic branchCond, takeBranch;
    logic isBranchID;
    aluClass aluClassCU;
    aluSrc2 aluSrc2CU;

    // execute stage
    logic regWriteEx, memReadEx, memWriteEx, memToRegEx, haltEx;
    aluClass aluClassEx;
    aluSrc2 aluSrc2Ex;
    logic [2:0] funct3Ex;
    logic [6:0] funct7Ex;
    regName rs1Ex, rs2Ex, rdEx;
    logic [XLEN-1:0] rs1DataEx, rs2DataEx, immIEx, immSEx, immUEx;
    logic [XLEN-1:0] opA, opB, aluB, aluOutEx;
    forwardSel fwdA, fwdB;

    // memory and writeback stages
    logic regWriteMem, memToRegMem, haltMem;
    regName rdMem, rdWb;
    logic regWriteWb, memToRegWb;
    logic [XLEN-1:0] aluOutWb, memDataWb, dataInWb;

    assign memBusy = (memRead || memWrite) && !memReady;

    // fetch, PC and IF/ID register
    // a bubble is the all-zero word
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pcIF    <= '0;
            running <= 1'b0;
            instrID <= '0;
        end else if (startProcess) begin
            pcIF    <= '0;
            running <= 1'b1;
            instrID <= '0;
        end else begin
            if (pcWrite && running) begin
                pcIF <= takeBranch ? targetID : pcIF + 32'd4;
                if (haltCU) begin
                    running <= 1'b0;
                end
            end
            if (ifIdWrite) begin
                instrID <= (!running || takeBranch || haltCU) ? '0 : instructionIF;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ifIdWrite) begin
            pcID <= pcIF;
        end
    end

    assign opcodeID = opcode'(instrID[6:0]);
    assign rdID     = regName'(instrID[11:7]);
    assign rs1ID    = regName'(instrID[19:15]);
    assign rs2ID    = regName'(instrID[24:20]);

    // stall detection looks at the raw opcode
    assign isBranchID = (opcodeID == OP_BRANCH);

    assign immI = {{20{instrID[31]}}, instrID[31:20]};
    assign immS = {{20{instrID[31]}}, instrID[31:25], instrID[11:7]};
    assign immB = {{19{instrID[31]}}, instrID[31], instrID[7], instrID[30:25],
                   instrID[11:8], 1'b0};
    assign immU = {instrID[31:12], 12'b0};
    assign immJ = {{11{instrID[31]}}, instrID[31], instrID[19:12], instrID[20],
                   instrID[30:21], 1'b0};

    controlUnit cu (
        .opcode(opcodeID), .enable(idExEnable),
        .regWrite(regWriteCU), .memRead(memReadCU), .memWrite(memWriteCU),
        .memToReg(memToRegCU), .branch(branchCU), .jump(jumpCU), .halt(haltCU),
        .aluClass(aluClassCU), .aluSrc2(aluSrc2CU)
    );

    regFile rf (
        .clk, .rstN, .wen(regWriteWb), .rs1(rs1ID), .rs2(rs2ID), .rd(rdWb),
        .dataIn(dataInWb), .rs1Data(rs1DataID), .rs2Data(rs2DataID)
    );

    hazardUnit hu (
        .rs1ID, .rs2ID, .rdEx, .memReadEx, .regWriteEx, .branchID(isBranchID),
        .memBusy, .pcWrite, .ifIdWrite, .idExEnable, .freeze
    );

    // branch operands forwarded from the memory stage
    // load data is valid on memReady
    assign memFwd = memToRegMem ? memRData : memAddr;
    assign cmpA = (regWriteMem && rdMem != x0 && rdMem == rs1ID) ? memFwd : rs1DataID;
    assign cmpB = (regWriteMem && rdMem != x0 && rdMem == rs2ID) ? memFwd : rs2DataID;

    always_comb begin
        case (instrID[14:12])
            F3_BEQ:  branchCond = (cmpA == cmpB);
            F3_BNE:  branchCond = (cmpA != cmpB);
            default: branchCond = 1'b0;
        endcase
    end

    assign takeBranch = jumpCU || (branchCU && branchCond);
    assign targetID   = pcID + (jumpCU ? immJ : immB);

    // ID/EX
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            regWriteEx <= 1'b0;
            memReadEx  <= 1'b0;
            memWriteEx <= 1'b0;
            memToRegEx <= 1'b0;
            haltEx     <= 1'b0;
        end else if (!freeze) begin
            regWriteEx <= regWriteCU;
            memReadEx  <= memReadCU;
            memWriteEx <= memWriteCU;
            memToRegEx <= memToRegCU;
            haltEx     <= haltCU;
        end
    end

    always_ff @(posedge clk) begin
        if (!freeze) begin
            aluClassEx <= aluClassCU;
            aluSrc2Ex  <= aluSrc2CU;
            funct3Ex   <= instrID[14:12];
            funct7Ex   <= instrID[31:25];
            rs1Ex      <= rs1ID;
            rs2Ex      <= rs2ID;
            rdEx       <= rdID;
            rs1DataEx  <= rs1DataID;
            rs2DataEx  <= rs2DataID;
            immIEx     <= immI;
            immSEx     <= immS;
            // JAL link address goes down the U slot
            immUEx     <= jumpCU ? pcID + 32'd4 : immU;
        end
    end

    // memory stage wins over writeback
    always_comb begin
        fwdA = FWD_REG;
        fwdB = FWD_REG;
        if (regWriteWb && rdWb != x0 && rdWb == rs1Ex) fwdA = FWD_WB;
        if (regWriteWb && rdWb != x0 && rdWb == rs2Ex) fwdB = FWD_WB;
        if (regWriteMem && rdMem != x0 && rdMem == rs1Ex) fwdA = FWD_MEM;
        if (regWriteMem && rdMem != x0 && rdMem == rs2Ex) fwdB = FWD_MEM;
    end

    always_comb begin
        case (fwdA)
            FWD_MEM: opA = memAddr;
            FWD_WB:  opA = dataInWb;
            default: opA = rs1DataEx;
        endcase
        case (fwdB)
            FWD_MEM: opB = memAddr;
            FWD_WB:  opB = dataInWb;
            default: opB = rs2DataEx;
        endcase
        case (aluSrc2Ex)
            SRC2_IMM_I: aluB = immIEx;
            SRC2_IMM_S: aluB = immSEx;
            SRC2_IMM_U: aluB = immUEx;
            default:    aluB = opB;
        endcase
    end

    alu exAlu (
        .aluClass(aluClassEx), .funct3(funct3Ex), .funct7(funct7Ex),
        .a(opA), .b(aluB), .result(aluOutEx), .zero()
    );

    // EX/MEM and MEM/WB control, plus the end flag
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            regWriteMem <= 1'b0;
            memToRegMem <= 1'b0;
            haltMem     <= 1'b0;
            memRead     <= 1'b0;
            memWrite    <= 1'b0;
            regWriteWb  <= 1'b0;
            memToRegWb  <= 1'b0;
            endProcess  <= 1'b0;
        end else begin
            if (startProcess) begin
                endProcess <= 1'b0;
            end else if (haltMem && !freeze) begin
                endProcess <= 1'b1;
            end
            if (!freeze) begin
                regWriteMem <= regWriteEx;
                memToRegMem <= memToRegEx;
                haltMem     <= haltEx;
                memRead     <= memReadEx;
                memWrite    <= memWriteEx;
                regWriteWb  <= regWriteMem;
                memToRegWb  <= memToRegMem;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!freeze) begin
            rdMem     <= rdEx;
            memAddr   <= aluOutEx;
            memWData  <= opB;
            rdWb      <= rdMem;
            aluOutWb  <= memAddr;
            memDataWb <= memRData;
        end
    end

    assign dataInWb = memToRegWb ? memDataWb : aluOutWb;

endmodule

// ==== source/instrMem.sv ====
// instruction memory
`timescale 1ns/1ps

module instrMem (
    input  logic                     clk,
    input  logic                     we,
    input  logic [isaPkg::XLEN-1:0]  loadAddr,
    input  logic [isaPkg::XLEN-1:0]  loadData,
    input  logic [isaPkg::XLEN-1:0]  pc,
    output logic [isaPkg::XLEN-1:0]  instruction
);
    import isaPkg::*;
    import corePkg::*;

    logic [XLEN-1:0] mem [IMEM_DEPTH];

    // loadAddr is a word index
    always_ff @(posedge clk) begin
        if (we) begin
            mem[loadAddr[$clog2(IMEM_DEPTH)-1:0]] <= loadData;
        end
    end

    // pc is a byte address
    assign instruction = mem[pc[2 +: $clog2(IMEM_DEPTH)]];

endmodule

// ==== source/dataMem.sv ====
// data memory with ready handshake
`timescale 1ns/1ps

module dataMem (
    input  logic                     clk,
    input  logic                     rstN,
    input  logic                     read,
    input  logic                     write,
    input  logic [isaPkg::XLEN-1:0]  addr,
    input  logic [isaPkg::XLEN-1:0]  wData,
    output logic [isaPkg::XLEN-1:0]  rData,
    output logic                     ready,
    input  logic                     loadWe,
    input  logic [isaPkg::XLEN-1:0]  loadAddr,
    input  logic [isaPkg::XLEN-1:0]  loadData,
    input  logic [isaPkg::XLEN-1:0]  dbgAddr,
    output logic [isaPkg::XLEN-1:0]  dbgData
);
    import isaPkg::*;
    import corePkg::*;

    logic [XLEN-1:0] mem [DMEM_DEPTH];
    logic [$clog2(DMEM_DEPTH)-1:0] wordIdx;

    assign wordIdx = addr[2 +: $clog2(DMEM_DEPTH)];

    // one wait cycle, then ready for a single cycle
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            ready <= 1'b0;
        end else begin
            ready <= (read || write) && !ready;
        end
    end

    always_ff @(posedge clk) begin
        if (loadWe) begin
            mem[loadAddr[$clog2(DMEM_DEPTH)-1:0]] <= loadData;
        end else if (write && ready) begin
            mem[wordIdx] <= wData;
        end
    end

    assign rData   = mem[wordIdx];
    // word-indexed inspection port
    assign dbgData = mem[dbgAddr[$clog2(DMEM_DEPTH)-1:0]];

endmodule

// ==== source/cpuSystem.sv ====
// processor with its memories
`timescale 1ns/1ps

module cpuSystem (
    input  logic                     clk,
    input  logic                     rstN,
    input  logic                     startProcess,
    output logic                     endProcess,
    input  logic                     imemWe,
    input  logic                     dmemWe,
    input  logic [isaPkg::XLEN-1:0]  loadAddr,
    input  logic [isaPkg::XLEN-1:0]  loadData,
    input  logic [isaPkg::XLEN-1:0]  dbgAddr,
    output logic [isaPkg::XLEN-1:0]  dbgData
);
    import isaPkg::*;

    logic [XLEN-1:0] pcIF, instructionIF;
    logic [XLEN-1:0] memAddr, memWData, memRData;
    logic memRead, memWrite, memReady;

    processor core (
        .clk, .rstN, .startProcess, .endProcess,
        .instructionIF, .pcIF,
        .memRData, .memReady, .memRead, .memWrite, .memAddr, .memWData
    );

    instrMem imem (
        .clk, .we(imemWe), .loadAddr, .loadData,
        .pc(pcIF), .instruction(instructionIF)
    );

    dataMem dmem (
        .clk, .rstN, .read(memRead), .write(memWrite), .addr(memAddr),
        .wData(memWData), .rData(memRData), .ready(memReady),
        .loadWe(dmemWe), .loadAddr, .loadData, .dbgAddr, .dbgData
    );

endmodule

// ==== verification/isaModel.svh ====
// reference model and program generator
`ifndef ISA_MODEL_SVH
`define ISA_MODEL_SVH

localparam int BODY_LEN  = 120;
localparam int TAIL_BASE = 48;
// funct3 of ADD SUB AND OR XOR SLT SLL SRL, entry 0 in the low bits
localparam logic [23:0] R_FUNCT3 = 24'b101_001_010_100_110_111_000_000;

logic [XLEN-1:0] progWords [$];
logic [XLEN-1:0] modelMem [DMEM_DEPTH];
logic [XLEN-1:0] modelRegs [32];

function automatic regName pickReg();
    // x0 about one time in eight
    if ($urandom % 8 == 0) begin
        return x0;
    end
    return regName'(5'(1 + $urandom % 15));
endfunction

task automatic genProgram();
    int kind;
    int sel;
    int skip;
    logic [12:0] off;
    logic [11:0] imm;
    logic [6:0] funct7;
    regName rd;
    regName ra;
    regName rb;
    progWords.delete();
    for (int i = 0; i < BODY_LEN; i++) begin
        kind = $urandom % 12;
        sel = $urandom % 8;
        rd = pickReg();
        ra = pickReg();
        rb = ($urandom % 4 == 0) ? ra : pickReg();
        imm = 12'(($urandom % DMEM_DEPTH) * 4);
        funct7 = (sel == 1) ? 7'h20 : 7'h00;
        // forward only, the furthest target is the first tail store
        skip = 2 + $urandom % 5;
        if (i + skip > BODY_LEN) begin
            skip = BODY_LEN - i;
        end
        if (kind >= 10 && skip < 2) begin
            kind = 0;
        end
        off = 13'(skip * 4);
        case (kind)
            4, 5: progWords.push_back({12'($urandom), ra, 3'b000, rd, OP_I});
            6: progWords.push_back({20'($urandom), rd, OP_LUI});
            7, 8: progWords.push_back({imm, ra, 3'b010, rd, OP_LOAD});
            9: progWords.push_back({imm[11:5], rb, ra, 3'b010, imm[4:0], OP_STORE});
            10: progWords.push_back({off[12], off[10:5], rb, ra, (sel[0] ? F3_BNE : F3_BEQ),
                                     off[4:1], off[11], OP_BRANCH});
            11: progWords.push_back({1'b0, off[10:1], off[11], 8'h00, rd, OP_JAL});
            default: progWords.push_back({funct7, rb, ra, R_FUNCT3[sel*3 +: 3], rd, OP_R});
        endcase
    end
    // tail dumps x1..x15 into words 48..62
    for (int r = 1; r < 16; r++) begin
        imm = 12'((TAIL_BASE + r - 1) * 4);
        progWords.push_back({imm[11:5], regName'(5'(r)), x0, 3'b010, imm[4:0], OP_STORE});
    end
    progWords.push_back({25'b0, OP_HALT});
endtask

// sequential run, one instruction per step
task automatic runModel();
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] nextPc;
    logic [XLEN-1:0] ins;
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    logic [XLEN-1:0] res;
    logic [XLEN-1:0] immI;
    logic [XLEN-1:0] immS;
    logic wr;
    foreach (modelRegs[i]) begin
        modelRegs[i] = '0;
    end
    pc = '0;
    ins = progWords[pc >> 2];
    while (ins[6:0] != OP_HALT) begin
        a = modelRegs[ins[19:15]];
        b = modelRegs[ins[24:20]];
        immI = 32'($signed(ins[31:20]));
        immS = 32'($signed({ins[31:25], ins[11:7]}));
        nextPc = pc + 32'd4;
        res = '0;
        wr = 1'b1;
        case (ins[6:0])
            OP_R: begin
                case ({ins[30], ins[14:12]})
                    4'b0000: res = a + b;
                    4'b1000: res = a - b;
                    4'b0111: res = a & b;
                    4'b0110: res = a | b;
                    4'b0100: res = a ^ b;
                    4'b0010: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    4'b0001: res = a << b[4:0];
                    default: res = a >> b[4:0];
                endcase
            end
            OP_I: res = a + immI;
            OP_LUI: res = {ins[31:12], 12'b0};
            OP_LOAD: res = modelMem[((a + immI) >> 2) % DMEM_DEPTH];
            OP_STORE: begin
                modelMem[((a + immS) >> 2) % DMEM_DEPTH] = b;
                wr = 1'b0;
            end
            OP_BRANCH: begin
                // funct3 bit 0 turns BEQ into BNE
                if ((a == b) ^ ins[12]) begin
                    nextPc = pc + 32'($signed({ins[31], ins[7], ins[30:25], ins[11:8], 1'b0}));
                end
                wr = 1'b0;
            end
            default: begin
                res = pc + 32'd4;
                nextPc = pc + 32'($signed({ins[31], ins[19:12], ins[20], ins[30:21], 1'b0}));
            end
        endcase
        if (wr && ins[11:7] != 5'd0) begin
            modelRegs[ins[11:7]] = res;
        end
        pc = nextPc;
        ins = progWords[pc >> 2];
    end
endtask

`endif

// ==== verification/tbCpuSystem.sv ====
// testbench for the pipelined RV32I core
`timescale 1ns/1ps

module tbCpuSystem;
    import isaPkg::*;
    import corePkg::*;

    `include "isaModel.svh"

    logic clk;
    logic rstN;
    logic startProcess;
    logic endProcess;
    logic imemWe;
    logic dmemWe;
    logic [XLEN-1:0] loadAddr;
    logic [XLEN-1:0] loadData;
    logic [XLEN-1:0] dbgAddr;
    logic [XLEN-1:0] dbgData;

    // cycle budget while the core runs
    int runCycles = 0;
    int cycleLimit = 0;
    logic counting = 1'b0;

    cpuSystem i_dut (
        .clk, .rstN, .startProcess, .endProcess, .imemWe, .dmemWe,
        .loadAddr, .loadData, .dbgAddr, .dbgData
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        if (counting) begin
            runCycles = runCycles + 1;
            if (runCycles >= cycleLimit) begin
                $display("timeout: endProcess did not rise within %0d cycles", cycleLimit);
                $display("Checks failed");
                $fatal(1, "run stopped by the cycle limit");
            end
        end
    end

    task automatic checkValue(input string name, input logic [XLEN-1:0] got,
                              input logic [XLEN-1:0] expected);
        if (got !== expected) begin
            $display("error at %0t: %s is %h, expected %h", $time, name, got, expected);
            $display("Checks failed");
            $fatal(1, "value mismatch");
        end
    endtask

    initial begin
        logic [XLEN-1:0] initData [DMEM_DEPTH];
        rstN = 1'b0;
        startProcess = 1'b0;
        imemWe = 1'b0;
        dmemWe = 1'b0;
        loadAddr = '0;
        loadData = '0;
        dbgAddr = '0;
        void'($urandom(23));
        genProgram();
        foreach (initData[i]) begin
            initData[i] = $urandom;
        end
        cycleLimit = 8 * progWords.size() + 200;

        repeat (2) @(negedge clk);
        rstN = 1'b1;
        @(negedge clk);
        checkValue("endProcess", 32'(endProcess), 32'd0);

        // program, then initial data, through the load ports
        foreach (progWords[i]) begin
            imemWe = 1'b1;
            loadAddr = i;
            loadData = progWords[i];
            @(negedge clk);
        end
        imemWe = 1'b0;
        foreach (initData[i]) begin
            dmemWe = 1'b1;
            loadAddr = i;
            loadData = initData[i];
            @(negedge clk);
        end
        dmemWe = 1'b0;
        modelMem = initData;
        runModel();
        checkValue("endProcess", 32'(endProcess), 32'd0);

        startProcess = 1'b1;
        counting = 1'b1;
        @(negedge clk);
        startProcess = 1'b0;
        while (!endProcess) begin
            @(negedge clk);
        end
        counting = 1'b0;

        // whole data memory against the model
        for (int i = 0; i < DMEM_DEPTH; i++) begin
            dbgAddr = i;
            @(negedge clk);
            checkValue("endProcess", 32'(endProcess), 32'd1);
            checkValue($sformatf("dmem[%0d]", i), dbgData, modelMem[i]);
        end
        $display("All checks passed");
        $finish;
    end

endmodule

// ==== project.f ====
+incdir+verification
source/isaPkg.sv
source/corePkg.sv
source/controlUnit.sv
source/regFile.sv
source/hazardUnit.sv
source/alu.sv
source/processor.sv
source/instrMem.sv
source/dataMem.sv
source/cpuSystem.sv
verification/tbCpuSystem.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -Wno-fatal --top-module tbCpuSystem -f project.f -o simv \
    || { echo "build failed"; exit 1; }
./obj_dir/simv > sim.log 2>&1 || echo "simulator returned a failing status"
cat sim.log
grep -q "Checks failed" sim.log && exit 1 || exit 0
